// ==== compile.f ====
source/lc3b_types.sv
source/control_rom.sv
source/alu.sv
source/instr_queue.sv
source/regfile.sv
source/lc3b_exec_pipe.sv
source/lc3b_exec_core.sv
dv/tb_lc3b_exec_core.sv

// ==== Makefile ====
TOP = tb_lc3b_exec_core

.PHONY: compile run clean

compile:
	verilator --binary --timing --assert -Wno-fatal --timescale 1ns/1ps \
		--top-module $(TOP) -f compile.f

run: compile
	@out="$$(./obj_dir/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "ALL CHECKS PASSED"

clean:
	rm -rf obj_dir

// ==== dv/tb_lc3b_exec_core.sv ====
`timescale 1ns/1ps

module tb_lc3b_exec_core;

   localparam int QUEUE_DEPTH = 4;
   localparam int OUT_CREDITS = 2;

   typedef struct packed {
      lc3b_types::lc3b_word pc;
      logic                 write;
      lc3b_types::lc3b_reg  dest;
      lc3b_types::lc3b_word data;
      logic [2:0]           cc;
      logic                 branch;
      logic                 chk_target;
      lc3b_types::lc3b_word target;
      logic                 mem_read;
      logic                 mem_write;
      logic                 chk_addr;
      lc3b_types::lc3b_word addr;
      logic                 chk_store;
      lc3b_types::lc3b_word store_data;
   } exp_rec_t;

   logic                 clk = 1'b0;
   logic                 arst_n;
   logic                 in_valid, in_credit, out_credit, out_valid;
   logic                 out_write, out_branch, out_mem_read, out_mem_write;
   lc3b_types::lc3b_word in_instr, in_pc, out_pc, out_data;
   lc3b_types::lc3b_word out_target, out_addr, out_store_data;
   lc3b_types::lc3b_reg  out_dest;
   logic [2:0]           out_cc;

   lc3b_types::lc3b_word m_regs [8];   // model state
   logic [2:0]           m_cc;
   lc3b_types::lc3b_word send_instr_q [$];
   lc3b_types::lc3b_word send_pc_q [$];
   exp_rec_t             exp_q [$];
   lc3b_types::lc3b_word next_pc = 16'h3000;
   integer               seed = 69;
   logic                 hold_credits;
   int n_queued = 0, n_sent = 0, n_credit_pulses = 0, n_records = 0, n_granted = 0;
   int value_errors = 0, flow_errors = 0, cycles = 0, slots_seen = OUT_CREDITS;

   lc3b_exec_core #(
      .QUEUE_DEPTH (QUEUE_DEPTH),
      .OUT_CREDITS (OUT_CREDITS)
   ) u_dut (
      .clk            (clk),
      .arst_n         (arst_n),
      .in_valid       (in_valid),
      .in_instr       (in_instr),
      .in_pc          (in_pc),
      .out_credit     (out_credit),
      .in_credit      (in_credit),
      .out_valid      (out_valid),
      .out_pc         (out_pc),
      .out_dest       (out_dest),
      .out_write      (out_write),
      .out_data       (out_data),
      .out_cc         (out_cc),
      .out_branch     (out_branch),
      .out_target     (out_target),
      .out_mem_read   (out_mem_read),
      .out_mem_write  (out_mem_write),
      .out_addr       (out_addr),
      .out_store_data (out_store_data)
   );

   always #20 clk = ~clk;

   // ISA level result of one instruction, updates the model registers and cc
   function automatic exp_rec_t predict(input lc3b_types::lc3b_word instr,
                                        input lc3b_types::lc3b_word pc);
      exp_rec_t               e;
      lc3b_types::lc3b_opcode op;
      lc3b_types::lc3b_word   sr1, sr2, imm, off6, off9, off11, val;
      logic                   setcc;
      e      = '0;
      op     = lc3b_types::lc3b_opcode'(instr[15:12]);
      sr1    = m_regs[instr[8:6]];
      sr2    = m_regs[instr[2:0]];
      off6   = {{10{instr[5]}}, instr[5:0]};
      off9   = {{6{instr[8]}}, instr[8:0], 1'b0};
      off11  = {{4{instr[10]}}, instr[10:0], 1'b0};
      val    = '0;
      setcc  = 1'b0;
      e.pc   = pc;
      e.dest = instr[11:9];
      case (op)
         lc3b_types::op_add, lc3b_types::op_and: begin
            imm = instr[5] ? {{11{instr[4]}}, instr[4:0]} : sr2;
            val = (op == lc3b_types::op_add) ? sr1 + imm : sr1 & imm;
            e.write = 1'b1;
            setcc   = 1'b1;
         end
         lc3b_types::op_not: begin
            val     = ~sr1;
            e.write = 1'b1;
            setcc   = 1'b1;
         end
         lc3b_types::op_shf: begin
            if (!instr[4]) begin
               val = sr1 << instr[3:0];
            end else if (!instr[5]) begin
               val = sr1 >> instr[3:0];
            end else begin
               val = sr1;
               for (int i = 0; i < 16; i++) begin
                  if (i < int'(instr[3:0])) val = {val[15], val[15:1]};   // sign fill
               end
            end
            e.write = 1'b1;
            setcc   = 1'b1;
         end
         lc3b_types::op_lea: begin
            val     = pc + off9;
            e.write = 1'b1;
            setcc   = 1'b1;
         end
         lc3b_types::op_br: begin
            e.branch     = 1'b1;
            e.chk_target = 1'b1;
            e.target     = pc + off9;
         end
         lc3b_types::op_jmp: begin
            e.chk_target = 1'b1;
            e.target     = sr1;
         end
         lc3b_types::op_jsr: begin
            e.chk_target = 1'b1;
            e.target     = instr[11] ? pc + off11 : sr1;   // base read before link
            e.write      = 1'b1;
            e.dest       = 3'd7;
            val          = pc;
         end
         lc3b_types::op_trap: begin
            e.write    = 1'b1;
            e.dest     = 3'd7;
            val        = pc;
            e.mem_read = 1'b1;
            e.chk_addr = 1'b1;
            e.addr     = {7'b0, instr[7:0], 1'b0};
         end
         lc3b_types::op_ldr, lc3b_types::op_ldi, lc3b_types::op_ldb: begin
            e.mem_read = 1'b1;
            e.chk_addr = 1'b1;
            e.addr     = sr1 + ((op == lc3b_types::op_ldb) ? off6 : off6 << 1);
         end
         lc3b_types::op_str, lc3b_types::op_sti, lc3b_types::op_stb: begin
            e.mem_write  = 1'b1;
            e.chk_addr   = 1'b1;
            e.addr       = sr1 + ((op == lc3b_types::op_stb) ? off6 : off6 << 1);
            e.chk_store  = 1'b1;
            e.store_data = m_regs[instr[11:9]];
         end
         default: ;   // rti retires with no effect
      endcase
      if (e.write) begin
         e.data         = val;
         m_regs[e.dest] = val;
      end
      if (setcc) m_cc = val[15] ? 3'b100 : (val == 16'h0) ? 3'b010 : 3'b001;
      e.cc = m_cc;
      return e;
   endfunction

   task automatic issue(input lc3b_types::lc3b_word instr);
      exp_q.push_back(predict(instr, next_pc));
      send_instr_q.push_back(instr);
      send_pc_q.push_back(next_pc);
      next_pc = next_pc + 16'd2;
      n_queued++;
   endtask

   task automatic wait_drain();
      while (send_instr_q.size() != 0 || exp_q.size() != 0 || n_granted != n_records) begin
         @(posedge clk);
      end
   endtask

   task automatic check_field(input string name, input logic [15:0] got,
                              input logic [15:0] exp, input lc3b_types::lc3b_word pc);
      assert (got === exp) else begin
         value_errors++;
         $display("ERROR %0t: pc %h field %s got %h expected %h", $time, pc, name, got, exp);
      end
   endtask

   // fetch side, sends only while it holds an input credit
   initial begin
      in_valid = 1'b0;
      in_instr = '0;
      in_pc    = '0;
      wait (arst_n === 1'b1);
      forever begin
         @(posedge clk);
         #2;
         if (send_instr_q.size() != 0 && QUEUE_DEPTH + n_credit_pulses - n_sent > 0) begin
            in_valid = 1'b1;
            in_instr = send_instr_q.pop_front();
            in_pc    = send_pc_q.pop_front();
            n_sent++;
         end else begin
            in_valid = 1'b0;
         end
      end
   end

   // consumer returns one slot per record after a random gap
   initial begin
      out_credit = 1'b0;
      wait (arst_n === 1'b1);
      forever begin
         @(posedge clk);
         #2;
         if (!hold_credits && n_granted < n_records && ($random(seed) % 3) != 0) begin
            out_credit = 1'b1;
            n_granted++;
         end else begin
            out_credit = 1'b0;
         end
      end
   end

   // compare process, outputs are settled at the falling edge
   always @(negedge clk) begin
      exp_rec_t e;
      if (in_credit) n_credit_pulses++;
      if (out_valid) begin
         assert (slots_seen > 0) else begin
            flow_errors++;
            $display("record with pc %h at %0t was sent without a granted slot", out_pc, $time);
         end
         assert (exp_q.size() != 0) else begin
            flow_errors++;
            $display("record with pc %h at %0t was not expected", out_pc, $time);
         end
         if (exp_q.size() != 0) begin
            e = exp_q.pop_front();
            check_field("pc", out_pc, e.pc, e.pc);
            check_field("write", 16'(out_write), 16'(e.write), e.pc);
            check_field("cc", 16'(out_cc), 16'(e.cc), e.pc);
            check_field("branch", 16'(out_branch), 16'(e.branch), e.pc);
            check_field("mem_read", 16'(out_mem_read), 16'(e.mem_read), e.pc);
            check_field("mem_write", 16'(out_mem_write), 16'(e.mem_write), e.pc);
            if (e.write) begin
               check_field("dest", 16'(out_dest), 16'(e.dest), e.pc);
               check_field("data", out_data, e.data, e.pc);
            end
            if (e.chk_target) check_field("target", out_target, e.target, e.pc);
            if (e.chk_addr) check_field("addr", out_addr, e.addr, e.pc);
            if (e.chk_store) check_field("store_data", out_store_data, e.store_data, e.pc);
         end
         n_records++;
      end
      slots_seen = slots_seen - int'(out_valid) + int'(out_credit);
   end

   initial begin
      while (cycles <= 40 * n_queued + 200) begin
         @(posedge clk);
         cycles++;
      end
      $display("timeout after %0d cycles with %0d records still expected", cycles, exp_q.size());
      $display("value errors: %0d, flow errors: %0d", value_errors, flow_errors);
      $display("CHECKS FAILED");
      $finish;
   end

   initial begin
      int base_records;
      int base_sent;
      int base_pops;
      arst_n       = 1'b0;
      hold_credits = 1'b0;
      m_cc         = 3'b000;
      for (int i = 0; i < 8; i++) begin
         m_regs[i] = '0;
      end
      repeat (10) @(posedge clk);
      #2;
      arst_n = 1'b1;

      issue({4'h1, 3'd1, 3'd0, 1'b1, 5'd7});     // add r1, r0, #7
      issue({4'h1, 3'd2, 3'd1, 1'b1, 5'h1d});    // add r2, r1, #-3
      issue({4'h5, 3'd3, 3'd1, 3'b000, 3'd2});   // and r3, r1, r2
      issue({4'h9, 3'd4, 3'd1, 6'h3f});          // not r4, r1
      issue({4'h1, 3'd1, 3'd4, 3'b000, 3'd3});   // add r1, r4, r3
      issue({4'h5, 3'd5, 3'd1, 1'b1, 5'h1e});    // and r5, r1, #-2
      issue({4'h7, 3'd5, 3'd1, 6'd1});           // str r5 right after its write
      issue({4'hd, 3'd6, 3'd4, 2'b00, 4'd3});    // lsl
      issue({4'hd, 3'd6, 3'd6, 2'b01, 4'd2});    // lsr
      issue({4'hd, 3'd7, 3'd4, 2'b11, 4'd5});    // asr of a negative value
      issue({4'hd, 3'd0, 3'd2, 2'b11, 4'd1});
      issue({4'he, 3'd5, 9'h1ec});               // lea r5, #-20
      issue({4'h0, 3'b111, 9'd10});              // br nzp
      issue({4'hc, 3'd0, 3'd2, 6'd0});           // jmp r2
      issue({4'h4, 1'b1, 11'h79c});              // jsr #-100
      issue({4'h4, 1'b0, 2'd0, 3'd3, 6'd0});     // jsrr r3
      issue({4'hf, 4'd0, 8'h25});                // trap x25
      issue({4'hc, 3'd0, 3'd7, 6'd0});           // ret uses the fresh link
      issue({4'h6, 3'd1, 3'd2, 6'd3});           // ldr
      issue({4'h2, 3'd1, 3'd2, 6'h3b});          // ldb #-5
      issue({4'h7, 3'd4, 3'd2, 6'h3f});          // str
      issue({4'h3, 3'd4, 3'd2, 6'd7});           // stb
      issue({4'ha, 3'd0, 3'd3, 6'd2});           // ldi
      issue({4'hb, 3'd5, 3'd6, 6'h38});          // sti #-8
      issue(16'h8000);                           // rti
      repeat (60) issue(16'($random(seed)));
      wait_drain();

      // withhold output slots and watch the pipe fill up
      hold_credits = 1'b1;
      base_records = n_records;
      base_sent    = n_sent;
      base_pops    = n_credit_pulses;
      repeat (12) issue(16'($random(seed)));
      repeat (60) @(posedge clk);
      assert (n_records - base_records <= OUT_CREDITS) else begin
         flow_errors++;
         $display("%0d records retired with no slots returned", n_records - base_records);
      end
      assert (n_sent - base_sent == QUEUE_DEPTH + OUT_CREDITS + 2) else begin
         flow_errors++;
         $display("%0d instructions accepted while stalled", n_sent - base_sent);
      end
      assert (n_credit_pulses - base_pops == OUT_CREDITS + 2) else begin
         flow_errors++;
         $display("%0d input credits returned while stalled", n_credit_pulses - base_pops);
      end
      hold_credits = 1'b0;
      wait_drain();

      $display("value errors: %0d, flow errors: %0d", value_errors, flow_errors);
      if (value_errors + flow_errors == 0) begin
         $display("ALL CHECKS PASSED");
      end else begin
         $display("CHECKS FAILED");
      end
      $finish;
   end

endmodule : tb_lc3b_exec_core

// ==== source/lc3b_exec_core.sv ====
`timescale 1ns/1ps

module lc3b_exec_core #(
   parameter int QUEUE_DEPTH = 4,
   parameter int OUT_CREDITS = 2
) (
   input  logic                 clk,
   input  logic                 arst_n,
   input  logic                 in_valid,
   input  lc3b_types::lc3b_word in_instr,
   input  lc3b_types::lc3b_word in_pc,
   input  logic                 out_credit,
   output logic                 in_credit,
   output logic                 out_valid,
   output lc3b_types::lc3b_word out_pc,
   output lc3b_types::lc3b_reg  out_dest,
   output logic                 out_write,
   output lc3b_types::lc3b_word out_data,
   output logic [2:0]           out_cc,
   output logic                 out_branch,
   output lc3b_types::lc3b_word out_target,
   output logic                 out_mem_read,
   output logic                 out_mem_write,
   output lc3b_types::lc3b_word out_addr,
   output lc3b_types::lc3b_word out_store_data
);

   logic                 head_valid, pop, wr_en;
   lc3b_types::lc3b_word head_instr, head_pc;
   lc3b_types::lc3b_word rd_data_a, rd_data_b, wr_data;
   lc3b_types::lc3b_reg  rd_idx_a, rd_idx_b, wr_idx;

   instr_queue #(
      .DEPTH (QUEUE_DEPTH)
   ) u_instr_queue (
      .clk        (clk),
      .arst_n     (arst_n),
      .push       (in_valid),
      .push_instr (in_instr),
      .push_pc    (in_pc),
      .pop        (pop),
      .head_valid (head_valid),
      .head_instr (head_instr),
      .head_pc    (head_pc),
      .credit     (in_credit)
   );

   regfile u_regfile (
      .clk       (clk),
      .arst_n    (arst_n),
      .wr_en     (wr_en),
      .wr_idx    (wr_idx),
      .wr_data   (wr_data),
      .rd_idx_a  (rd_idx_a),
      .rd_idx_b  (rd_idx_b),
      .rd_data_a (rd_data_a),
      .rd_data_b (rd_data_b)
   );

   lc3b_exec_pipe #(
      .OUT_CREDITS (OUT_CREDITS)
   ) u_exec_pipe (
      .clk            (clk),
      .arst_n         (arst_n),
      .head_valid     (head_valid),
      .head_instr     (head_instr),
      .head_pc        (head_pc),
      .rd_data_a      (rd_data_a),
      .rd_data_b      (rd_data_b),
      .out_credit     (out_credit),
      .pop            (pop),
      .rd_idx_a       (rd_idx_a),
      .rd_idx_b       (rd_idx_b),
      .wr_en          (wr_en),
      .wr_idx         (wr_idx),
      .wr_data        (wr_data),
      .out_valid      (out_valid),
      .out_pc         (out_pc),
      .out_dest       (out_dest),
      .out_write      (out_write),
      .out_data       (out_data),
      .out_cc         (out_cc),
      .out_branch     (out_branch),
      .out_target     (out_target),
      .out_mem_read   (out_mem_read),
      .out_mem_write  (out_mem_write),
      .out_addr       (out_addr),
      .out_store_data (out_store_data)
   );

endmodule : lc3b_exec_core

// ==== source/lc3b_exec_pipe.sv ====
`timescale 1ns/1ps

module lc3b_exec_pipe #(
   parameter int OUT_CREDITS = 2
) (
   input  logic                 clk,
   input  logic                 arst_n,
   input  logic                 head_valid,
   input  lc3b_types::lc3b_word head_instr,
   input  lc3b_types::lc3b_word head_pc,
   input  lc3b_types::lc3b_word rd_data_a,
   input  lc3b_types::lc3b_word rd_data_b,
   input  logic                 out_credit,
   output logic                 pop,
   output lc3b_types::lc3b_reg  rd_idx_a,
   output lc3b_types::lc3b_reg  rd_idx_b,
   output logic                 wr_en,
   output lc3b_types::lc3b_reg  wr_idx,
   output lc3b_types::lc3b_word wr_data,
   output logic                 out_valid,
   output lc3b_types::lc3b_word out_pc,
   output lc3b_types::lc3b_reg  out_dest,
   output logic                 out_write,
   output lc3b_types::lc3b_word out_data,
   output logic [2:0]           out_cc,
   output logic                 out_branch,
   output lc3b_types::lc3b_word out_target,
   output logic                 out_mem_read,
   output logic                 out_mem_write,
   output lc3b_types::lc3b_word out_addr,
   output lc3b_types::lc3b_word out_store_data
);

   localparam int SW = $clog2(OUT_CREDITS + 1);

   lc3b_types::lc3b_control_word dec_ctrl;
   lc3b_types::lc3b_control_word s1_ctrl;
   logic                 s1_valid, s1_adv, s2_valid, s2_adv;
   lc3b_types::lc3b_word s1_instr, s1_pc, s1_a, s1_b;
   lc3b_types::lc3b_reg  s1_idx_a, s1_idx_b;
   lc3b_types::lc3b_word op_a, op_b, alu_a, alu_b, alu_f;
   lc3b_types::lc3b_word off6, off9s, off11s, trap_vec;
   lc3b_types::lc3b_word x_data, x_target, x_addr;
   logic                 x_write, x_setcc;
   logic [2:0]           x_nzp, cc, s2_nzp;
   lc3b_types::lc3b_reg  x_dest;
   logic                 s2_setcc;
   logic [SW-1:0]        slots;

   control_rom u_control_rom (
      .opcode     (lc3b_types::lc3b_opcode'(head_instr[15:12])),
      .bits4_5_11 ({head_instr[11], head_instr[5], head_instr[4]}),
      .ctrl       (dec_ctrl)
   );

   // read indices come straight from the queue head
   assign rd_idx_a = head_instr[8:6];
   assign rd_idx_b = dec_ctrl.storemux_sel ? head_instr[11:9] : head_instr[2:0];

   assign out_valid = s2_valid && (slots != '0);
   assign s2_adv    = !s2_valid || out_valid;
   assign s1_adv    = !s1_valid || s2_adv;
   assign pop       = head_valid && s1_adv;

   // forward the S2 write value over a stale read
   assign s1_idx_a = s1_instr[8:6];
   assign s1_idx_b = s1_ctrl.storemux_sel ? s1_instr[11:9] : s1_instr[2:0];
   assign op_a     = (s2_valid && out_write && out_dest == s1_idx_a) ? out_data : s1_a;
   assign op_b     = (s2_valid && out_write && out_dest == s1_idx_b) ? out_data : s1_b;

   assign off6     = s1_ctrl.offset6mux_sel ? {{10{s1_instr[5]}}, s1_instr[5:0]}
                                            : {{9{s1_instr[5]}}, s1_instr[5:0], 1'b0};
   assign off9s    = {{6{s1_instr[8]}}, s1_instr[8:0], 1'b0};
   assign off11s   = {{4{s1_instr[10]}}, s1_instr[10:0], 1'b0};
   assign trap_vec = {7'b0, s1_instr[7:0], 1'b0};

   assign alu_a = s1_ctrl.alubasemux_sel ? s1_pc : op_a;

   always_comb begin
      case (s1_ctrl.alumux_sel)
         3'b001:  alu_b = off6;
         3'b010:  alu_b = off9s;
         3'b011:  alu_b = {{11{s1_instr[4]}}, s1_instr[4:0]};   // imm5
         3'b100:  alu_b = {12'b0, s1_instr[3:0]};               // imm4
         default: alu_b = op_b;
      endcase
   end

   alu u_alu (
      .aluop (s1_ctrl.aluop),
      .a     (alu_a),
      .b     (alu_b),
      .f     (alu_f)
   );

   assign x_target = (s1_ctrl.pcmux_sel == 2'b10) ? alu_f
                   : s1_pc + (s1_ctrl.offsetmux_sel ? off11s : off9s);
   assign x_addr   = (s1_ctrl.marmux_sel == 2'b01) ? trap_vec : alu_f;
   assign x_data   = (s1_ctrl.regfilemux_sel == 2'b10) ? s1_pc : alu_f;   // link or result
   assign x_write  = s1_ctrl.load_regfile && (s1_ctrl.regfilemux_sel != 2'b01);
   assign x_dest   = s1_ctrl.destmux_sel ? 3'd7 : s1_instr[11:9];
   assign x_setcc  = s1_ctrl.load_cc && !s1_ctrl.mem_read && !s1_ctrl.mem_write;
   assign x_nzp    = {x_data[15], x_data == '0, !x_data[15] && x_data != '0};

   assign out_cc  = s2_setcc ? s2_nzp : cc;
   assign wr_en   = out_valid && out_write;
   assign wr_idx  = out_dest;
   assign wr_data = out_data;

   always_ff @(posedge clk) begin
      if (pop) begin
         s1_ctrl  <= dec_ctrl;
         s1_instr <= head_instr;
         s1_pc    <= head_pc;
         s1_a     <= rd_data_a;
         s1_b     <= rd_data_b;
      end
      if (s2_adv && s1_valid) begin
         out_pc         <= s1_pc;
         out_dest       <= x_dest;
         out_write      <= x_write;
         out_data       <= x_data;
         s2_setcc       <= x_setcc;
         s2_nzp         <= x_nzp;
         out_branch     <= s1_ctrl.valid_branch;
         out_target     <= x_target;
         out_mem_read   <= s1_ctrl.mem_read;
         out_mem_write  <= s1_ctrl.mem_write;
         out_addr       <= x_addr;
         out_store_data <= op_b;
      end
   end

   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         s1_valid <= 1'b0;
         s2_valid <= 1'b0;
         cc       <= 3'b000;
         slots    <= SW'(OUT_CREDITS);
      end else begin
         if (s1_adv) begin
            s1_valid <= head_valid;
         end
         if (s2_adv) begin
            s2_valid <= s1_valid;
         end
         if (out_valid && s2_setcc) begin
            cc <= s2_nzp;   // cc changes as the record leaves
         end
         case ({out_valid, out_credit})
            2'b10:   slots <= slots - 1'b1;
            2'b01:   slots <= slots + 1'b1;
            default: slots <= slots;
         endcase
      end
   end

endmodule : lc3b_exec_pipe

// ==== source/regfile.sv ====
`timescale 1ns/1ps

module regfile (
   input  logic                 clk,
   input  logic                 arst_n,
   input  logic                 wr_en,
   input  lc3b_types::lc3b_reg  wr_idx,
   input  lc3b_types::lc3b_word wr_data,
   input  lc3b_types::lc3b_reg  rd_idx_a,
   input  lc3b_types::lc3b_reg  rd_idx_b,
   output lc3b_types::lc3b_word rd_data_a,
   output lc3b_types::lc3b_word rd_data_b
);

   lc3b_types::lc3b_word regs [8];

   // same-cycle write is visible on the read ports
   assign rd_data_a = (wr_en && wr_idx == rd_idx_a) ? wr_data : regs[rd_idx_a];
   assign rd_data_b = (wr_en && wr_idx == rd_idx_b) ? wr_data : regs[rd_idx_b];

   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         for (int i = 0; i < 8; i++) begin
            regs[i] <= '0;
         end
      end else if (wr_en) begin
         regs[wr_idx] <= wr_data;
      end
   end

endmodule : regfile

// ==== source/instr_queue.sv ====
`timescale 1ns/1ps

module instr_queue #(
   parameter int DEPTH = 4
) (
   input  logic                 clk,
   input  logic                 arst_n,
   input  logic                 push,
   input  lc3b_types::lc3b_word push_instr,
   input  lc3b_types::lc3b_word push_pc,
   input  logic                 pop,
   output logic                 head_valid,
   output lc3b_types::lc3b_word head_instr,
   output lc3b_types::lc3b_word head_pc,
   output logic                 credit
);

   localparam int PW = (DEPTH > 1) ? $clog2(DEPTH) : 1;
   localparam int CW = $clog2(DEPTH + 1);

   lc3b_types::lc3b_word instr_mem [DEPTH];
   lc3b_types::lc3b_word pc_mem [DEPTH];
   logic [PW-1:0]        wr_ptr;
   logic [PW-1:0]        rd_ptr;
   logic [CW-1:0]        count;
   logic                 do_pop;

   assign head_valid = (count != '0);
   assign head_instr = instr_mem[rd_ptr];
   assign head_pc    = pc_mem[rd_ptr];
   assign do_pop     = pop && head_valid;
   assign credit     = do_pop;   // one credit back per freed entry

   always_ff @(posedge clk) begin
      if (push) begin
         instr_mem[wr_ptr] <= push_instr;
         pc_mem[wr_ptr]    <= push_pc;
      end
   end

   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         wr_ptr <= '0;
         rd_ptr <= '0;
         count  <= '0;
      end else begin
         if (push) begin
            wr_ptr <= (wr_ptr == PW'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
         end
         if (do_pop) begin
            rd_ptr <= (rd_ptr == PW'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
         end
         case ({push, do_pop})
            2'b10:   count <= count + 1'b1;
            2'b01:   count <= count - 1'b1;
            default: count <= count;   // both or neither
         endcase
      end
   end

endmodule : instr_queue

// ==== source/alu.sv ====
`timescale 1ns/1ps

module alu (
   input  lc3b_types::lc3b_aluop aluop,
   input  lc3b_types::lc3b_word  a,
   input  lc3b_types::lc3b_word  b,
   output lc3b_types::lc3b_word  f
);

   logic [3:0] shamt;

   assign shamt = b[3:0];   // imm4 shift amount

   always_comb begin
      case (aluop)
         lc3b_types::alu_add:  f = a + b;
         lc3b_types::alu_and:  f = a & b;
         lc3b_types::alu_not:  f = ~a;
         lc3b_types::alu_pass: f = a;
         lc3b_types::alu_sll:  f = a << shamt;
         lc3b_types::alu_srl:  f = a >> shamt;
         lc3b_types::alu_sra:  f = $signed(a) >>> shamt;
         default:              f = a;
      endcase
   end

endmodule : alu

// ==== source/control_rom.sv ====
`timescale 1ns/1ps

module control_rom (
   input  lc3b_types::lc3b_opcode       opcode,
   input  logic [2:0]                   bits4_5_11,   // {bit 11, bit 5, bit 4}
   output lc3b_types::lc3b_control_word ctrl
);

   always_comb begin
      ctrl                = '0;
      ctrl.opcode         = opcode;
      ctrl.aluop          = lc3b_types::alu_add;

      case (opcode)
         lc3b_types::op_add, lc3b_types::op_and: begin
            ctrl.aluop        = (opcode == lc3b_types::op_add) ? lc3b_types::alu_add
                                                               : lc3b_types::alu_and;
            ctrl.alumux_sel   = bits4_5_11[1] ? 3'b011 : 3'b000;   // imm5 or sr2
            ctrl.load_cc      = 1'b1;
            ctrl.load_regfile = 1'b1;
            ctrl.valid_dest   = 1'b1;
         end

         lc3b_types::op_not: begin
            ctrl.aluop        = lc3b_types::alu_not;
            ctrl.load_cc      = 1'b1;
            ctrl.load_regfile = 1'b1;
            ctrl.valid_dest   = 1'b1;
         end

         lc3b_types::op_shf: begin
            if (!bits4_5_11[0]) begin
               ctrl.aluop = lc3b_types::alu_sll;   // d clear
            end else if (!bits4_5_11[1]) begin
               ctrl.aluop = lc3b_types::alu_srl;   // a clear
            end else begin
               ctrl.aluop = lc3b_types::alu_sra;
            end
            ctrl.alumux_sel   = 3'b100;   // imm4 amount
            ctrl.load_cc      = 1'b1;
            ctrl.load_regfile = 1'b1;
            ctrl.valid_dest   = 1'b1;
         end

         lc3b_types::op_lea: begin
            ctrl.alumux_sel     = 3'b010;
            ctrl.alubasemux_sel = 1'b1;   // pc + offset9<<1
            ctrl.load_cc        = 1'b1;
            ctrl.load_regfile   = 1'b1;
            ctrl.valid_dest     = 1'b1;
         end

         lc3b_types::op_br: begin
            ctrl.pcmux_sel    = 2'b01;
            ctrl.valid_branch = 1'b1;   // taken check done by fetch
         end

         lc3b_types::op_jmp: begin
            ctrl.aluop     = lc3b_types::alu_pass;
            ctrl.pcmux_sel = 2'b10;   // base register
         end

         lc3b_types::op_jsr: begin
            ctrl.regfilemux_sel = 2'b10;   // link pc
            ctrl.load_regfile   = 1'b1;
            ctrl.destmux_sel    = 1'b1;
            if (bits4_5_11[2]) begin
               ctrl.offsetmux_sel = 1'b1;   // jsr, offset11
               ctrl.pcmux_sel     = 2'b01;
            end else begin
               ctrl.aluop     = lc3b_types::alu_pass;   // jsrr base
               ctrl.pcmux_sel = 2'b10;
            end
         end

         lc3b_types::op_trap: begin
            ctrl.regfilemux_sel = 2'b10;
            ctrl.load_regfile   = 1'b1;
            ctrl.destmux_sel    = 1'b1;
            ctrl.marmux_sel     = 2'b01;   // vector address
            ctrl.mem_read       = 1'b1;
            ctrl.mdrmux_sel     = 2'b01;
            ctrl.pcmux_sel      = 2'b11;   // new pc from memory
         end

         lc3b_types::op_ldr, lc3b_types::op_ldi, lc3b_types::op_ldb: begin
            ctrl.mem_read       = 1'b1;
            ctrl.mdrmux_sel     = 2'b01;
            ctrl.alumux_sel     = 3'b001;
            ctrl.regfilemux_sel = 2'b01;   // value comes from memory stage
            ctrl.load_regfile   = 1'b1;
            ctrl.load_cc        = 1'b1;
            ctrl.valid_dest     = 1'b1;
            if (opcode == lc3b_types::op_ldb) begin
               ctrl.wordinmux_sel  = 1'b1;
               ctrl.offset6mux_sel = 1'b1;
            end
         end

         lc3b_types::op_str, lc3b_types::op_stb: begin
            ctrl.mem_write    = 1'b1;
            ctrl.alumux_sel   = 3'b001;
            ctrl.storemux_sel = 1'b1;
            if (opcode == lc3b_types::op_stb) begin
               ctrl.mdrmux_sel     = 2'b10;   // byte write data
               ctrl.offset6mux_sel = 1'b1;
            end
         end

         lc3b_types::op_sti: begin
            // address phase only, second cycle is the state controller's
            ctrl.mem_write      = 1'b1;
            ctrl.mdrmux_sel     = 2'b01;
            ctrl.alumux_sel     = 3'b001;
            ctrl.regfilemux_sel = 2'b01;
            ctrl.storemux_sel   = 1'b1;
            ctrl.load_cc        = 1'b1;
         end

         default: begin
            ctrl = '0;   // rti and unused
         end
      endcase
   end

endmodule : control_rom

// ==== source/lc3b_types.sv ====
package lc3b_types;

   typedef logic [15:0] lc3b_word;   // data and address word
   typedef logic [2:0]  lc3b_reg;    // register index

   typedef enum logic [3:0] {
      op_br   = 4'b0000,
      op_add  = 4'b0001,
      op_ldb  = 4'b0010,
      op_stb  = 4'b0011,
      op_jsr  = 4'b0100,   // also jsrr
      op_and  = 4'b0101,
      op_ldr  = 4'b0110,
      op_str  = 4'b0111,
      op_rti  = 4'b1000,
      op_not  = 4'b1001,
      op_ldi  = 4'b1010,
      op_sti  = 4'b1011,
      op_jmp  = 4'b1100,   // also ret
      op_shf  = 4'b1101,
      op_lea  = 4'b1110,
      op_trap = 4'b1111
   } lc3b_opcode;

   typedef enum logic [2:0] {
      alu_add,
      alu_and,
      alu_not,
      alu_pass,
      alu_sll,
      alu_srl,
      alu_sra
   } lc3b_aluop;

   typedef struct packed {
      lc3b_opcode opcode;
      lc3b_aluop  aluop;
      logic       load_cc;
      logic       load_pc;
      logic       load_regfile;
      logic [2:0] alumux_sel;       // sr2, offset6, offset9 shifted, imm5, imm4
      logic [1:0] pcmux_sel;        // 01 pc+offset, 10 alu, 11 memory
      logic       mem_read;
      logic       mem_write;
      logic       offsetmux_sel;    // offset11 for the target adder
      logic       storemux_sel;     // second read index from bits 11:9
      logic       destmux_sel;      // dest forced to r7
      logic [1:0] regfilemux_sel;   // 00 alu, 01 memory, 10 pc
      logic [1:0] marmux_sel;       // 01 trap vector
      logic [1:0] mdrmux_sel;
      logic       wordinmux_sel;
      logic       offset6mux_sel;   // unshifted offset6 for bytes
      logic       valid_branch;
      logic       valid_dest;
      logic       alubasemux_sel;   // pc as alu base
   } lc3b_control_word;

endpackage : lc3b_types
